//--- rv_golden.f
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/rv_io_pkg.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_result.sv
rtl/rv_golden_top.sv
verification/wb_mem_model.sv
verification/rv_golden_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rv_golden testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f rv_golden.f --top-module rv_golden_tb -o rv_golden_sim

./obj_dir/rv_golden_sim > sim.log 2>&1
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"

//--- verification/rv_golden_tb.sv
`include "rv_golden_consts.svh"

module rv_golden_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_io_pkg::*;

    localparam int          RESET_CYCLES  = 16;
    localparam int          CYCLES_PER_OP = 16;
    localparam int          NUM_TESTS     = 6;
    localparam int          OP_COUNT [NUM_TESTS] = '{40, 30, 24, 32, 49, 60};
    localparam logic [15:0] DATA_KEY      = 16'ha5c3;

    logic    clk;
    logic    rst;
    logic    op_valid;
    logic    op_ready;
    op_req_t op_req;
    logic    res_valid;
    logic    res_ready;
    op_res_t res;
    wb_m2s_t wb_m2s;
    wb_s2m_t wb_s2m;

    op_res_t exp_q[$];   // expected results in input order
    logic    in_fire_q;  // input transfer on the last edge
    logic    stalled_q;
    op_res_t held_q;
    logic    bus_ack_q;  // wishbone ack seen on the last edge
    int      ready_mode; // 0 random ready, 1 long stalls
    int      checks;
    int      errors;
    int      results;
    int      cycles;

    rv_golden_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .op_valid_i (op_valid),
        .op_ready_o (op_ready),
        .op_i       (op_req),
        .res_valid_o(res_valid),
        .res_ready_i(res_ready),
        .res_o      (res),
        .wbm_o      (wb_m2s),
        .wbm_i      (wb_s2m)
    );

    wb_mem_model #(.DATA_KEY(DATA_KEY)) mem0 (
        .clk  (clk),
        .rst  (rst),
        .wbs_i(wb_m2s),
        .wbs_o(wb_s2m)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic string test_name(int t);
        case (t)
            0: return "xori";
            1: return "auipc";
            2: return "blt";
            3: return "lb";
            4: return "legality";
            default: return "backpressure";
        endcase
    endfunction

    function automatic logic [31:0] word_at(logic [31:0] adr);
        return {~adr[15:0], adr[15:0] ^ adr[31:16] ^ DATA_KEY};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    // rv32i legality straight from the encoding tables
    function automatic bit legal_rv32i(logic [31:0] w);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = w[14:12];
        f7 = w[31:25];
        case (w[6:0])
            7'h37, 7'h17: return 1'b1;                 // lui, auipc
            7'h6f: return !w[21];                      // jal, offset bit 1
            7'h67: return (f3 == 3'd0) && (w[21:20] == 2'b00);
            7'h63: return (f3 != 3'd2) && (f3 != 3'd3) && !w[8];
            7'h03: return f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
            7'h23: return f3 <= 3'd2;
            7'h13: begin
                if (f3 == 3'd1) return f7 == 7'h00;
                if (f3 == 3'd5) return (f7 == 7'h00) || (f7 == 7'h20);
                return 1'b1;
            end
            7'h33: return (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5));
            7'h0f: begin
                if (w[19:15] != 5'd0 || w[11:7] != 5'd0) return 1'b0;
                return ((f3 == 3'd0) && (w[31:28] == 4'd0))
                    || ((f3 == 3'd1) && (w[31:20] == 12'd0));
            end
            7'h73: return (w[31:21] == 11'd0) && (w[19:7] == 13'd0); // ecall, ebreak
            default: return 1'b0;
        endcase
    endfunction

    function automatic op_res_t ref_result(op_req_t r);
        op_res_t     e;
        logic [31:0] w;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] ea;
        logic [31:0] word;
        logic [7:0]  lane;
        logic [31:0] val;
        bit          branch;
        w       = r.inst;
        imm_i   = {{20{w[31]}}, w[31:20]};
        imm_b   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        e.rd    = w[11:7];
        e.next_pc = r.pc + 32'(`RV_PC_STEP);
        e.status  = ST_UNSUPPORTED;
        val     = '0;
        branch  = 1'b0;
        if (!legal_rv32i(w)) begin
            e.status = ST_ILLEGAL;
        end else if (w[6:0] == 7'h13 && w[14:12] == 3'd4) begin
            e.status = ST_DONE;
            val      = r.rs1_val ^ imm_i;
        end else if (w[6:0] == 7'h17) begin
            e.status = ST_DONE;
            val      = {w[31:12], 12'h000} + r.pc;
        end else if (w[6:0] == 7'h03 && w[14:12] == 3'd0) begin
            e.status = ST_DONE;
            ea       = r.rs1_val + imm_i;
            word     = word_at({ea[31:2], 2'b00});
            lane     = word[{ea[1:0], 3'b000} +: 8]; // little-endian byte lanes
            val      = {{24{lane[7]}}, lane};
        end else if (w[6:0] == 7'h63 && w[14:12] == 3'd4) begin
            e.status = ST_DONE;
            branch   = 1'b1;
            if ($signed(r.rs1_val) < $signed(r.rs2_val)) e.next_pc = r.pc + imm_b;
        end
        e.we    = (e.status == ST_DONE) && (e.rd != 5'd0) && !branch;
        e.wdata = e.we ? val : 32'h0;
        return e;
    endfunction

    // fence, system, bad funct7, misaligned branches and a few legal odd ones
    function automatic logic [31:0] legality_word(int idx, logic [31:0] rnd);
        logic [31:0] w;
        case (idx % 7)
            0: w = rnd;
            1: begin
                if (rnd[1]) w = {rnd[2] ? 12'd0 : rnd[31:20], 5'd0, 3'b001, 5'd0, 7'h0f};
                else w = {rnd[0] ? 4'd0 : rnd[31:28], rnd[27:20], 5'd0, 3'b000, 5'd0, 7'h0f};
                if (rnd[3]) w[19:15] = rnd[8:4];
            end
            2: begin
                w = {11'd0, rnd[0], 13'd0, 7'h73};
                if (rnd[1]) w = w ^ (32'h80 << rnd[6:2]);
            end
            3: w = {rnd[0] ? rnd[31:25] : (rnd[1] ? 7'h20 : 7'h00), rnd[24:7], 7'h33};
            4: w = enc_b(rnd[12:0] & 13'h1ffe, rnd[24:20], rnd[19:15], rnd[27:25]);
            5: w = {rnd[31:15], rnd[0] ? 3'b001 : 3'b101, rnd[11:7], 7'h13};
            default: w = {rnd[31:15], 3'b000, rnd[11:7], 7'h67}; // jalr
        endcase
        return w;
    endfunction

    function automatic op_req_t gen_op(int kind, int idx);
        op_req_t     r;
        logic [31:0] rnd;
        logic [31:0] ea;
        logic [11:0] imm;
        logic [4:0]  rd;
        r.pc      = $urandom & 32'hffff_fffc;
        r.rs1_val = $urandom;
        r.rs2_val = $urandom;
        rnd       = $urandom;
        rd        = ($urandom_range(0, 3) == 0) ? 5'd0 : rnd[21:17];
        case (kind)
            0: r.inst = enc_i(rnd[11:0], rnd[16:12], 3'b100, rd, 7'h13);
            1: r.inst = {rnd[31:12], rd, 7'h17};
            2: begin
                case (idx % 6)
                    0: {r.rs1_val, r.rs2_val} = {32'h8000_0000, 32'h7fff_ffff};
                    1: {r.rs1_val, r.rs2_val} = {32'h8000_0000, 32'h8000_0000};
                    2: r.rs2_val = r.rs1_val;
                    3: {r.rs1_val, r.rs2_val} = {32'hffff_ffff, 32'h0000_0000};
                    4: {r.rs1_val, r.rs2_val} = {32'h0000_0000, 32'hffff_ffff};
                    default: ;
                endcase
                r.inst = enc_b({rnd[12:2], 2'b00}, rnd[24:20], rnd[19:15], 3'b100);
            end
            3: begin
                imm       = rnd[31:20];
                ea        = {r.rs2_val[31:2], 2'(idx % 4)}; // walk all byte offsets
                r.rs1_val = ea - {{20{imm[11]}}, imm};
                r.inst    = enc_i(imm, rnd[19:15], 3'b000, rd, 7'h03);
            end
            default: r.inst = legality_word(idx, rnd);
        endcase
        return r;
    endfunction

    task automatic check_field(string name, logic [31:0] got, logic [31:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic send_op(op_req_t r, int idle_pct);
        while (int'($urandom_range(0, 99)) < idle_pct) begin
            op_valid = 1'b0;
            @(negedge clk);
        end
        op_valid = 1'b1;
        op_req   = r;
        do begin
            @(negedge clk);
        end while (!in_fire_q);
        op_valid = 1'b0;
    endtask

    // expected results are queued on acceptance and popped on each output transfer
    always @(posedge clk) begin : compare_proc
        op_res_t want;
        if (rst) begin
            in_fire_q <= 1'b0;
            stalled_q <= 1'b0;
            bus_ack_q <= 1'b0;
        end else begin
            in_fire_q <= op_valid && op_ready;
            if (op_valid && op_ready) exp_q.push_back(ref_result(op_req));
            if (stalled_q) begin
                checks++;
                assert (res_valid && res == held_q) else begin
                    errors++;
                    $display("Mismatch at %0t: res_o while stalled got %h expected %h",
                             $time, res, held_q);
                end
            end
            // load port is a read-only master on full words
            if (wb_m2s.cyc) begin
                check_field("wbm_o.stb", 32'(wb_m2s.stb), 32'd1);
                check_field("wbm_o.we", 32'(wb_m2s.we), 32'd0);
                check_field("wbm_o.sel", 32'(wb_m2s.sel), 32'hf);
                check_field("wbm_o.adr[1:0]", 32'(wb_m2s.adr[1:0]), 32'd0);
            end
            if (bus_ack_q) begin
                checks++;
                assert (!wb_m2s.cyc) else begin
                    errors++;
                    $display("error at %0t: wishbone cycle still open on the edge after ack",
                             $time);
                end
            end
            if (res_valid && res_ready) begin
                results++;
                assert (exp_q.size() != 0) else begin
                    errors++;
                    $display("error at %0t: result arrived with no record outstanding", $time);
                end
                if (exp_q.size() != 0) begin
                    want = exp_q.pop_front();
                    check_field("res_o.status", 32'(res.status), 32'(want.status));
                    check_field("res_o.rd", 32'(res.rd), 32'(want.rd));
                    check_field("res_o.we", 32'(res.we), 32'(want.we));
                    check_field("res_o.wdata", res.wdata, want.wdata);
                    check_field("res_o.next_pc", res.next_pc, want.next_pc);
                end
            end
            stalled_q <= res_valid && !res_ready;
            held_q    <= res;
            bus_ack_q <= wb_m2s.cyc && wb_s2m.ack;
        end
    end

    initial begin : ready_proc
        int stall_left;
        int open_left;
        res_ready  = 1'b0;
        stall_left = 0;
        open_left  = 0;
        forever begin
            @(negedge clk);
            if (ready_mode == 0) begin
                res_ready = 1'($urandom_range(0, 1));
            end else if (stall_left > 0) begin
                res_ready = 1'b0;
                stall_left--;
            end else if (open_left > 0) begin
                res_ready = 1'b1;
                open_left--;
            end else begin
                stall_left = $urandom_range(8, 24); // long stall, short open window
                open_left  = $urandom_range(1, 4);
            end
        end
    end

    initial begin : timeout_proc
        int limit;
        limit  = RESET_CYCLES;
        cycles = 0;
        foreach (OP_COUNT[t]) limit += CYCLES_PER_OP * OP_COUNT[t];
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not end within %0d cycles, %0d results outstanding",
                 limit, exp_q.size());
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : main_proc
        int idle_pct;
        int err_base;
        int chk_base;
        int kind;
        void'($urandom(32'h51e0abca));
        rst        = 1'b1;
        op_valid   = 1'b0;
        op_req     = '0;
        ready_mode = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            err_base   = errors;
            chk_base   = checks;
            ready_mode = (t == NUM_TESTS - 1) ? 1 : 0;
            idle_pct   = $urandom_range(30, 50);
            for (int i = 0; i < OP_COUNT[t]; i++) begin
                kind = (t == NUM_TESTS - 1) ? int'($urandom_range(0, 4)) : t;
                send_op(gen_op(kind, i), idle_pct);
            end
            while (exp_q.size() != 0) @(negedge clk);
            $display("test %0d %s: %0d checks, %0d errors", t + 1, test_name(t),
                     checks - chk_base, errors - err_base);
        end
        $display("summary: %0d results, %0d checks, %0d errors", results, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- verification/wb_mem_model.sv
`include "rv_golden_consts.svh"

module wb_mem_model #(
    parameter logic [15:0] DATA_KEY = 16'h0000
) (
    input  logic               clk,
    input  logic               rst,
    input  rv_io_pkg::wb_m2s_t wbs_i,
    output rv_io_pkg::wb_s2m_t wbs_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic                ack_q  = 1'b0;
    logic [`RV_XLEN-1:0] dat_q  = '0;
    logic                busy_q = 1'b0; // request seen, counting wait states
    logic [1:0]          wait_q = '0;

    // upper half is the inverted low address bits, lower half mixes in the rest
    function automatic logic [`RV_XLEN-1:0] word_at(logic [`RV_XLEN-1:0] adr);
        return {~adr[15:0], adr[15:0] ^ adr[31:16] ^ DATA_KEY};
    endfunction

    always @(negedge clk) begin
        if (rst) begin
            ack_q  <= 1'b0;
            busy_q <= 1'b0;
            wait_q <= '0;
        end else if (ack_q) begin
            ack_q <= 1'b0; // master closed the cycle on the edge that saw ack
        end else if (wbs_i.cyc && wbs_i.stb) begin
            if (!busy_q) begin
                busy_q <= 1'b1;
                wait_q <= 2'($urandom_range(0, 3));
            end else if (wait_q == 2'd0) begin
                ack_q  <= 1'b1;
                dat_q  <= word_at(wbs_i.adr);
                busy_q <= 1'b0;
            end else begin
                wait_q <= wait_q - 2'd1;
            end
        end
    end

    assign wbs_o.ack = ack_q;
    assign wbs_o.dat = dat_q;

endmodule

//--- rtl/rv_golden_top.sv
`include "rv_golden_consts.svh"

module rv_golden_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               op_valid_i,
    output logic               op_ready_o,
    input  rv_io_pkg::op_req_t op_i,
    output logic               res_valid_o,
    input  logic               res_ready_i,
    output rv_io_pkg::op_res_t res_o,
    output rv_io_pkg::wb_m2s_t wbm_o,
    input  rv_io_pkg::wb_s2m_t wbm_i
);
    import rv_isa_pkg::*;
    import rv_io_pkg::*;

    logic      dec_valid;
    logic      dec_ready;
    dec_inst_t dec;
    op_pair_t  ops;
    logic      ex_valid;
    logic      ex_ready;
    ex_res_t   ex;

    rv_decode dec0 (
        .clk        (clk),
        .rst        (rst),
        .in_valid_i (op_valid_i),
        .in_ready_o (op_ready_o),
        .req_i      (op_i),
        .out_valid_o(dec_valid),
        .out_ready_i(dec_ready),
        .dec_o      (dec),
        .ops_o      (ops)
    );

    rv_execute exe0 (
        .clk        (clk),
        .rst        (rst),
        .in_valid_i (dec_valid),
        .in_ready_o (dec_ready),
        .dec_i      (dec),
        .ops_i      (ops),
        .out_valid_o(ex_valid),
        .out_ready_i(ex_ready),
        .ex_o       (ex),
        .wbm_o      (wbm_o),
        .wbm_i      (wbm_i)
    );

    rv_result res0 (
        .clk        (clk),
        .rst        (rst),
        .in_valid_i (ex_valid),
        .in_ready_o (ex_ready),
        .ex_i       (ex),
        .res_valid_o(res_valid_o),
        .res_ready_i(res_ready_i),
        .res_o      (res_o)
    );

endmodule

//--- rtl/rv_result.sv
`include "rv_golden_consts.svh"

module rv_result (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid_i,
    output logic               in_ready_o,
    input  rv_io_pkg::ex_res_t ex_i,
    output logic               res_valid_o,
    input  logic               res_ready_i,
    output rv_io_pkg::op_res_t res_o
);
    import rv_isa_pkg::*;
    import rv_io_pkg::*;

    op_status_t status_d;
    logic       we_d;
    op_res_t    res_d;
    op_res_t    res_q;
    logic       vld_q;

    always_comb begin
        case (ex_i.cls)
            CLS_ILLEGAL: status_d = ST_ILLEGAL;
            CLS_OTHER: status_d = ST_UNSUPPORTED;
            default: status_d = ST_DONE;
        endcase
    end

    // x0 never written, branches never write
    assign we_d = (status_d == ST_DONE) && (ex_i.rd != `RV_REG_AW'(0))
        && (ex_i.cls != CLS_BLT);

    always_comb begin
        res_d.status  = status_d;
        res_d.rd      = ex_i.rd;
        res_d.we      = we_d;
        res_d.wdata   = we_d ? ex_i.value : `RV_XLEN'(0);
        res_d.next_pc = ex_i.next_pc;
    end

    assign in_ready_o  = !vld_q || res_ready_i;
    assign res_valid_o = vld_q;
    assign res_o       = res_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= 1'b0;
        end else if (in_ready_o) begin
            vld_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            res_q <= res_d;
        end
    end

    // a stalled result stays put until the consumer takes it
    a_res_stable: assert property (@(posedge clk) disable iff (rst)
        res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_o));

endmodule

//--- rtl/rv_execute.sv
`include "rv_golden_consts.svh"

module rv_execute (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  rv_isa_pkg::dec_inst_t dec_i,
    input  rv_io_pkg::op_pair_t   ops_i,
    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output rv_io_pkg::ex_res_t    ex_o,
    output rv_io_pkg::wb_m2s_t    wbm_o,
    input  rv_io_pkg::wb_s2m_t    wbm_i
);
    import rv_isa_pkg::*;
    import rv_io_pkg::*;

    logic                vld_q;
    logic                cyc_q; // also marks a load in progress
    logic [`RV_XLEN-1:0] adr_q;
    logic [1:0]          boff_q;
    ex_res_t             ex_d;
    ex_res_t             ex_q;
    logic [`RV_XLEN-1:0] ea;
    logic [`RV_XLEN-1:0] seq_pc;
    logic [`RV_XLEN-1:0] lb_word;
    logic [`RV_XLEN-1:0] lb_byte;
    logic                blt_taken;
    logic                is_lb;
    logic                acc;
    logic                ack;

    // no new item while the bus access is open
    assign in_ready_o = !cyc_q && (!vld_q || out_ready_i);
    assign acc        = in_valid_i && in_ready_o;
    assign ack        = cyc_q && wbm_i.ack;

    assign ea        = ops_i.rs1_val + dec_i.imm_i;
    assign seq_pc    = dec_i.pc + `RV_XLEN'(`RV_PC_STEP);
    assign blt_taken = $signed(ops_i.rs1_val) < $signed(ops_i.rs2_val);
    assign is_lb     = (dec_i.cls == CLS_LB);

    always_comb begin
        ex_d.cls     = dec_i.cls;
        ex_d.rd      = dec_i.rd;
        ex_d.value   = '0;
        ex_d.next_pc = seq_pc;
        case (dec_i.cls)
            CLS_XORI: ex_d.value = ops_i.rs1_val ^ dec_i.imm_i;
            CLS_AUIPC: ex_d.value = dec_i.imm_u + dec_i.pc;
            CLS_BLT: begin
                if (blt_taken) ex_d.next_pc = dec_i.pc + dec_i.imm_b;
            end
            default: ex_d.value = '0; // lb value arrives with ack
        endcase
    end

    // byte lane from the low address bits, then sign-extend
    assign lb_word = wbm_i.dat >> {boff_q, 3'b000};
    assign lb_byte = {{(`RV_XLEN-8){lb_word[7]}}, lb_word[7:0]};

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= 1'b0;
            cyc_q <= 1'b0;
        end else if (ack) begin
            vld_q <= 1'b1; // load result ready
            cyc_q <= 1'b0;
        end else if (in_ready_o) begin
            vld_q <= in_valid_i && !is_lb;
            cyc_q <= in_valid_i && is_lb;
        end
    end

    always_ff @(posedge clk) begin
        if (acc) begin
            ex_q   <= ex_d;
            adr_q  <= {ea[`RV_XLEN-1:2], 2'b00}; // word aligned
            boff_q <= ea[1:0];
        end else if (ack) begin
            ex_q.value <= lb_byte;
        end
    end

    assign out_valid_o = vld_q;
    assign ex_o        = ex_q;

    // read-only master
    always_comb begin
        wbm_o.cyc = cyc_q;
        wbm_o.stb = cyc_q;
        wbm_o.we  = 1'b0;
        wbm_o.adr = adr_q;
        wbm_o.sel = '1;
        wbm_o.dat = '0;
    end

    // request held steady until the slave answers
    a_wb_hold: assert property (@(posedge clk) disable iff (rst)
        wbm_o.cyc && !wbm_i.ack |=> wbm_o.cyc && wbm_o.stb && $stable(wbm_o.adr));

endmodule

//--- rtl/rv_decode.sv
`include "rv_golden_consts.svh"

module rv_decode (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  rv_io_pkg::op_req_t    req_i,
    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output rv_isa_pkg::dec_inst_t dec_o,
    output rv_io_pkg::op_pair_t   ops_o
);
    import rv_isa_pkg::*;

    logic [`RV_XLEN-1:0]  inst;
    logic [`RV_OPC_W-1:0] opc;
    dec_inst_t            dec_d;
    dec_inst_t            dec_q;
    rv_io_pkg::op_pair_t  ops_q;
    logic                 legal;
    op_class_t            cls;
    logic                 vld_q;

    assign inst = req_i.inst;
    assign opc  = inst[`RV_OPC_W-1:0];

    always_comb begin
        legal = 1'b0;
        cls   = CLS_OTHER;
        case (opc)
            OPC_LUI: legal = 1'b1;
            OPC_AUIPC: begin
                legal = 1'b1;
                cls   = CLS_AUIPC;
            end
            OPC_JAL: legal = !inst[21]; // imm[1] of the jump offset
            OPC_JALR: legal = (dec_d.funct3 == F3_JALR) && (dec_d.imm_i[1:0] == 2'b00);
            OPC_B: begin
                legal = (dec_d.funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU})
                    && (dec_d.imm_b[1:0] == 2'b00);
                if (dec_d.funct3 == F3_BLT) cls = CLS_BLT;
            end
            OPC_IL: begin
                legal = dec_d.funct3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU};
                if (dec_d.funct3 == F3_LB) cls = CLS_LB;
            end
            OPC_S: legal = dec_d.funct3 inside {F3_SB, F3_SH, F3_SW};
            OPC_I: begin
                // funct7 only matters for shifts, elsewhere it is immediate
                legal = (dec_d.funct3 inside {F3_ADD, F3_SLT, F3_SLTU, F3_XOR, F3_OR, F3_AND})
                    || ((dec_d.funct3 == F3_SLL) && (dec_d.funct7 == F7_BASE))
                    || ((dec_d.funct3 == F3_SR) && (dec_d.funct7 inside {F7_BASE, F7_ALT}));
                if (dec_d.funct3 == F3_XOR) cls = CLS_XORI;
            end
            OPC_R: legal = (dec_d.funct7 == F7_BASE)
                || ((dec_d.funct7 == F7_ALT) && (dec_d.funct3 inside {F3_ADD, F3_SR}));
            OPC_FENCE: begin
                // fence: fm zero, pred/succ free; fence.i: everything above opcode zero
                legal = ((inst[31:28] == 4'b0) && (dec_d.funct3 == F3_FENCE)
                         && (dec_d.rs1 == '0) && (dec_d.rd == '0))
                     || ((inst[31:20] == 12'b0) && (dec_d.funct3 == F3_FENCE_I)
                         && (dec_d.rs1 == '0) && (dec_d.rd == '0));
            end
            OPC_E: legal = (inst[31:21] == 11'b0) && (inst[19:7] == 13'b0); // bit 20 picks ebreak
            default: legal = 1'b0;
        endcase
        if (!legal) cls = CLS_ILLEGAL;
    end

    always_comb begin
        dec_d.rd     = inst[`RV_RD_LSB +: `RV_REG_AW];
        dec_d.rs1    = inst[`RV_RS1_LSB +: `RV_REG_AW];
        dec_d.rs2    = inst[`RV_RS2_LSB +: `RV_REG_AW];
        dec_d.funct3 = inst[`RV_F3_LSB +: `RV_F3_W];
        dec_d.funct7 = inst[`RV_F7_LSB +: `RV_F7_W];
        dec_d.imm_i  = {{20{inst[31]}}, inst[31:20]};
        dec_d.imm_b  = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        dec_d.imm_u  = {inst[31:12], 12'b0};
        dec_d.cls    = cls;
        dec_d.pc     = req_i.pc;
    end

    // stage takes a new record when empty or when its own leaves
    assign in_ready_o  = !vld_q || out_ready_i;
    assign out_valid_o = vld_q;
    assign dec_o       = dec_q;
    assign ops_o       = ops_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= 1'b0;
        end else if (in_ready_o) begin
            vld_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            dec_q         <= dec_d;
            ops_q.rs1_val <= req_i.rs1_val;
            ops_q.rs2_val <= req_i.rs2_val;
        end
    end

endmodule

//--- rtl/rv_io_pkg.sv
`include "rv_golden_consts.svh"

package rv_io_pkg;

    // one instruction record from the producer
    typedef struct packed {
        logic [`RV_XLEN-1:0] inst;
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] rs1_val;
        logic [`RV_XLEN-1:0] rs2_val;
    } op_req_t;

    // source operand values carried alongside the decoded record
    typedef struct packed {
        logic [`RV_XLEN-1:0] rs1_val;
        logic [`RV_XLEN-1:0] rs2_val;
    } op_pair_t;

    typedef enum logic [1:0] {
        ST_DONE        = 2'd0,
        ST_UNSUPPORTED = 2'd1,
        ST_ILLEGAL     = 2'd2
    } op_status_t;

    // architectural outcome of one record
    typedef struct packed {
        op_status_t            status;
        logic [`RV_REG_AW-1:0] rd;
        logic                  we;
        logic [`RV_XLEN-1:0]   wdata;
        logic [`RV_XLEN-1:0]   next_pc;
    } op_res_t;

    // wishbone classic, master to slave
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [`RV_XLEN-1:0]  adr;
        logic [`RV_SEL_W-1:0] sel;
        logic [`RV_XLEN-1:0]  dat;
    } wb_m2s_t;

    // wishbone classic, slave to master
    typedef struct packed {
        logic                ack;
        logic [`RV_XLEN-1:0] dat;
    } wb_s2m_t;

    // execute to result
    typedef struct packed {
        rv_isa_pkg::op_class_t cls;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   value;
        logic [`RV_XLEN-1:0]   next_pc;
    } ex_res_t;

endpackage

//--- rtl/rv_isa_pkg.sv
`include "rv_golden_consts.svh"

package rv_isa_pkg;

    // rv32i major opcodes
    typedef enum logic [`RV_OPC_W-1:0] {
        OPC_R     = 7'b0110011, // register-register alu
        OPC_I     = 7'b0010011, // register-immediate alu
        OPC_IL    = 7'b0000011, // loads
        OPC_JALR  = 7'b1100111,
        OPC_S     = 7'b0100011, // stores
        OPC_B     = 7'b1100011, // branches
        OPC_JAL   = 7'b1101111,
        OPC_LUI   = 7'b0110111,
        OPC_AUIPC = 7'b0010111,
        OPC_FENCE = 7'b0001111, // fence, fence.i
        OPC_E     = 7'b1110011  // ecall, ebreak
    } opcode_t;

    // what the engine does with a record
    typedef enum logic [2:0] {
        CLS_XORI    = 3'd0,
        CLS_LB      = 3'd1,
        CLS_BLT     = 3'd2,
        CLS_AUIPC   = 3'd3,
        CLS_OTHER   = 3'd4, // legal but not computed here
        CLS_ILLEGAL = 3'd5
    } op_class_t;

    // alu funct3, shared by OPC_R and OPC_I
    localparam logic [`RV_F3_W-1:0] F3_ADD  = 3'b000;
    localparam logic [`RV_F3_W-1:0] F3_SLL  = 3'b001;
    localparam logic [`RV_F3_W-1:0] F3_SLT  = 3'b010;
    localparam logic [`RV_F3_W-1:0] F3_SLTU = 3'b011;
    localparam logic [`RV_F3_W-1:0] F3_XOR  = 3'b100;
    localparam logic [`RV_F3_W-1:0] F3_SR   = 3'b101; // srl/sra, split by funct7
    localparam logic [`RV_F3_W-1:0] F3_OR   = 3'b110;
    localparam logic [`RV_F3_W-1:0] F3_AND  = 3'b111;

    // funct7 for alu ops and shifts
    localparam logic [`RV_F7_W-1:0] F7_BASE = 7'b0000000;
    localparam logic [`RV_F7_W-1:0] F7_ALT  = 7'b0100000; // sub, sra, srai

    // loads
    localparam logic [`RV_F3_W-1:0] F3_LB  = 3'b000;
    localparam logic [`RV_F3_W-1:0] F3_LH  = 3'b001;
    localparam logic [`RV_F3_W-1:0] F3_LW  = 3'b010;
    localparam logic [`RV_F3_W-1:0] F3_LBU = 3'b100;
    localparam logic [`RV_F3_W-1:0] F3_LHU = 3'b101;

    // stores
    localparam logic [`RV_F3_W-1:0] F3_SB = 3'b000;
    localparam logic [`RV_F3_W-1:0] F3_SH = 3'b001;
    localparam logic [`RV_F3_W-1:0] F3_SW = 3'b010;

    // branches
    localparam logic [`RV_F3_W-1:0] F3_BEQ  = 3'b000;
    localparam logic [`RV_F3_W-1:0] F3_BNE  = 3'b001;
    localparam logic [`RV_F3_W-1:0] F3_BLT  = 3'b100;
    localparam logic [`RV_F3_W-1:0] F3_BGE  = 3'b101;
    localparam logic [`RV_F3_W-1:0] F3_BLTU = 3'b110;
    localparam logic [`RV_F3_W-1:0] F3_BGEU = 3'b111;

    // misc
    localparam logic [`RV_F3_W-1:0] F3_JALR    = 3'b000;
    localparam logic [`RV_F3_W-1:0] F3_FENCE   = 3'b000;
    localparam logic [`RV_F3_W-1:0] F3_FENCE_I = 3'b001;

    // decoded instruction, immediates already sign-extended
    typedef struct packed {
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_F3_W-1:0]   funct3;
        logic [`RV_F7_W-1:0]   funct7;
        logic [`RV_XLEN-1:0]   imm_i;
        logic [`RV_XLEN-1:0]   imm_b;
        logic [`RV_XLEN-1:0]   imm_u; // low 12 bits zero
        op_class_t             cls;
        logic [`RV_XLEN-1:0]   pc;
    } dec_inst_t;

endpackage

//--- rtl/rv_golden_consts.svh
`ifndef RV_GOLDEN_CONSTS_SVH
`define RV_GOLDEN_CONSTS_SVH

// data and address width
`define RV_XLEN 32

// register index width
`define RV_REG_AW 5

// sequential pc increment
`define RV_PC_STEP 4

// instruction field widths
`define RV_OPC_W 7
`define RV_F3_W 3
`define RV_F7_W 7

// instruction field positions (lsb)
`define RV_RD_LSB 7
`define RV_F3_LSB 12
`define RV_RS1_LSB 15
`define RV_RS2_LSB 20
`define RV_F7_LSB 25

// wishbone byte select width
`define RV_SEL_W 4

`endif
